// ==== Makefile ====
SIM     := obj_dir/Vtb_serdes_link
SOURCES := $(shell cat all.f)

.PHONY: run clean

run: $(SIM)
	./$(SIM) > sim.log 2>&1; cat sim.log
	grep -q "Simulation PASSED" sim.log

$(SIM): $(SOURCES) all.f
	verilator --binary --timing --assert -Wno-fatal --top-module tb_serdes_link -f all.f

clean:
	rm -rf obj_dir sim.log

// ==== all.f ====
serdes_pkg.sv
serdes_reset_seq.sv
serdes_serializer.sv
serdes_in_delay.sv
serdes_deserializer.sv
serdes_word_align.sv
serdes_link.sv
tb_clock_gen.sv
tb_serdes_link.sv

// ==== serdes_deserializer.sv ====
`default_nettype none

module serdes_deserializer #(
    parameter int DATA_WIDTH = serdes_pkg::WORD_BITS
) (
    input  wire                   CLKDIV,
    input  wire                   link_rst,
    input  wire                   dly_dat,
    input  wire                   slip,
    output logic [DATA_WIDTH-1:0] rx_word,
    output logic                  rx_stb
);

    localparam int               CNT_W    = $clog2(DATA_WIDTH);
    localparam logic [CNT_W-1:0] LAST_BIT = CNT_W'(DATA_WIDTH - 1);

    logic [CNT_W-1:0]      bit_cnt;
    logic [DATA_WIDTH-1:0] shreg;
    logic [DATA_WIDTH-1:0] next_shreg;
    logic                  wrap;

    // new bits enter at the top so the oldest ends up in bit 0
    assign next_shreg = {dly_dat, shreg[DATA_WIDTH-1:1]};
    assign wrap       = (bit_cnt == LAST_BIT) && !slip;

    always_ff @(posedge CLKDIV) begin
        shreg <= next_shreg;
    end

    // slip holds the counter one cycle, moving the boundary one bit
    always_ff @(posedge CLKDIV) begin
        if (link_rst) begin
            bit_cnt <= '0;
        end else if (slip) begin
            bit_cnt <= bit_cnt;
        end else if (wrap) begin
            bit_cnt <= '0;
        end else begin
            bit_cnt <= bit_cnt + 1'b1;
        end
    end

    always_ff @(posedge CLKDIV) begin
        if (link_rst) begin
            rx_stb <= 1'b0;
        end else begin
            rx_stb <= wrap;
        end
    end

    always_ff @(posedge CLKDIV) begin
        if (wrap) begin
            rx_word <= next_shreg;
        end
    end

    // aligner answers a word one cycle late, never on the strobe itself
    a_slip_vs_stb: assert property (
        @(posedge CLKDIV) disable iff (link_rst)
        slip |-> !rx_stb
    );

endmodule

`default_nettype wire

// ==== serdes_in_delay.sv ====
`default_nettype none

module serdes_in_delay #(
    parameter int DELAY_TAPS = 16
) (
    input  wire  CLKDIV,
    input  wire  link_rst,
    input  wire  i_dat,
    output logic dly_dat
);

    logic [DELAY_TAPS-1:0] taps;

    // fixed tap chain, one cycle per tap
    always_ff @(posedge CLKDIV) begin
        if (link_rst) begin
            taps <= '0;
        end else begin
            taps <= {taps[DELAY_TAPS-2:0], i_dat};
        end
    end

    assign dly_dat = taps[DELAY_TAPS-1];

endmodule

`default_nettype wire

// ==== serdes_link.sv ====
`default_nettype none

module serdes_link #(
    parameter int DATA_WIDTH = serdes_pkg::WORD_BITS,
    parameter int DELAY_TAPS = 16
) (
    input  wire                   CLKDIV,
    input  wire                   RST,
    input  wire  [DATA_WIDTH-1:0] tx_data,
    output logic                  tx_stb,
    output logic                  o_dat,
    input  wire                   i_dat,
    output logic [DATA_WIDTH-1:0] rx_data,
    output logic                  rx_valid,
    output logic                  locked,
    output logic                  rdy
);

    logic                  link_rst;
    logic                  dly_dat;
    logic [DATA_WIDTH-1:0] rx_word;
    logic                  rx_stb;
    logic                  slip;

    serdes_reset_seq u_reset_seq (
        .CLKDIV   (CLKDIV),
        .RST      (RST),
        .link_rst (link_rst),
        .rdy      (rdy)
    );

    serdes_serializer #(.DATA_WIDTH(DATA_WIDTH)) u_serializer (
        .CLKDIV   (CLKDIV),
        .link_rst (link_rst),
        .locked   (locked),
        .tx_data  (tx_data),
        .tx_stb   (tx_stb),
        .o_dat    (o_dat)
    );

    serdes_in_delay #(.DELAY_TAPS(DELAY_TAPS)) u_in_delay (
        .CLKDIV   (CLKDIV),
        .link_rst (link_rst),
        .i_dat    (i_dat),
        .dly_dat  (dly_dat)
    );

    serdes_deserializer #(.DATA_WIDTH(DATA_WIDTH)) u_deserializer (
        .CLKDIV   (CLKDIV),
        .link_rst (link_rst),
        .dly_dat  (dly_dat),
        .slip     (slip),
        .rx_word  (rx_word),
        .rx_stb   (rx_stb)
    );

    serdes_word_align #(.DATA_WIDTH(DATA_WIDTH)) u_word_align (
        .CLKDIV   (CLKDIV),
        .link_rst (link_rst),
        .rx_word  (rx_word),
        .rx_stb   (rx_stb),
        .slip     (slip),
        .locked   (locked)
    );

    // received words count only after training
    assign rx_data  = rx_word;
    assign rx_valid = rx_stb && locked;

endmodule

`default_nettype wire

// ==== serdes_pkg.sv ====
`default_nettype none

package serdes_pkg;

    // default parallel word width
    localparam int WORD_BITS = 8;

    // training word, no rotation of it equals itself
    localparam logic [WORD_BITS-1:0] TRAIN_PATTERN = 8'hB4;

    // consecutive training matches before lock
    localparam int LOCK_MATCHES = 4;

    // words ignored after a bitslip while the boundary settles
    localparam int SLIP_SETTLE_WORDS = 2;

    // link reset held this many cycles after RST falls
    localparam int RST_STRETCH = 4;

    // calibration countdown before rdy
    localparam int CAL_CYCLES = 32;

endpackage

`default_nettype wire

// ==== serdes_reset_seq.sv ====
`default_nettype none

module serdes_reset_seq (
    input  wire  CLKDIV,
    input  wire  RST,
    output logic link_rst,
    output logic rdy
);

    import serdes_pkg::*;

    localparam int STRETCH_W = $clog2(RST_STRETCH + 1);
    localparam int CAL_W     = $clog2(CAL_CYCLES + 1);

    logic [STRETCH_W-1:0] stretch_cnt;
    logic [CAL_W-1:0]     cal_cnt;

    // stretch the link reset past the falling edge of RST
    always_ff @(posedge CLKDIV) begin
        if (RST) begin
            stretch_cnt <= STRETCH_W'(RST_STRETCH);
            link_rst    <= 1'b1;
        end else if (stretch_cnt != '0) begin
            stretch_cnt <= stretch_cnt - 1'b1;
            link_rst    <= 1'b1;
        end else begin
            link_rst <= 1'b0;
        end
    end

    // calibration countdown, restarts whenever the link is in reset
    always_ff @(posedge CLKDIV) begin
        if (RST || link_rst) begin
            cal_cnt <= CAL_W'(CAL_CYCLES);
            rdy     <= 1'b0;
        end else if (cal_cnt != '0) begin
            cal_cnt <= cal_cnt - 1'b1;
            rdy     <= (cal_cnt == CAL_W'(1));
        end
    end

    // ready only once the stretched reset is over
    a_rdy_after_rst: assert property (
        @(posedge CLKDIV) disable iff (RST)
        link_rst |-> !rdy
    );

endmodule

`default_nettype wire

// ==== serdes_serializer.sv ====
`default_nettype none

module serdes_serializer #(
    parameter int DATA_WIDTH = serdes_pkg::WORD_BITS
) (
    input  wire                   CLKDIV,
    input  wire                   link_rst,
    input  wire                   locked,
    input  wire  [DATA_WIDTH-1:0] tx_data,
    output logic                  tx_stb,
    output logic                  o_dat
);

    import serdes_pkg::*;

    localparam int                    CNT_W      = $clog2(DATA_WIDTH);
    localparam logic [CNT_W-1:0]      LAST_BIT   = CNT_W'(DATA_WIDTH - 1);
    localparam logic [DATA_WIDTH-1:0] TRAIN_WORD = DATA_WIDTH'(TRAIN_PATTERN);

    logic [CNT_W-1:0]      bit_cnt;
    logic [DATA_WIDTH-1:0] shreg;
    logic                  load;

    // load on the last bit slot, so the first edge after reset loads
    assign load   = (bit_cnt == LAST_BIT);
    assign tx_stb = load && locked;

    // lsb goes out first
    assign o_dat = shreg[0];

    always_ff @(posedge CLKDIV) begin
        if (link_rst) begin
            bit_cnt <= LAST_BIT;
        end else if (load) begin
            bit_cnt <= '0;
        end else begin
            bit_cnt <= bit_cnt + 1'b1;
        end
    end

    // line stays quiet in reset
    always_ff @(posedge CLKDIV) begin
        if (link_rst) begin
            shreg <= '0;
        end else if (load) begin
            shreg <= locked ? tx_data : TRAIN_WORD;
        end else begin
            shreg <= shreg >> 1;
        end
    end

    // while locked the strobe recurs once per word
    a_stb_period: assert property (
        @(posedge CLKDIV) disable iff (link_rst)
        (locked && $past(tx_stb, DATA_WIDTH)) |-> tx_stb
    );

endmodule

`default_nettype wire

// ==== serdes_word_align.sv ====
`default_nettype none

module serdes_word_align #(
    parameter int DATA_WIDTH = serdes_pkg::WORD_BITS
) (
    input  wire                   CLKDIV,
    input  wire                   link_rst,
    input  wire  [DATA_WIDTH-1:0] rx_word,
    input  wire                   rx_stb,
    output logic                  slip,
    output logic                  locked
);

    import serdes_pkg::*;

    localparam int                    MATCH_W    = $clog2(LOCK_MATCHES);
    localparam int                    SETTLE_W   = $clog2(SLIP_SETTLE_WORDS + 1);
    localparam logic [DATA_WIDTH-1:0] TRAIN_WORD = DATA_WIDTH'(TRAIN_PATTERN);

    logic [MATCH_W-1:0]  match_cnt;
    logic [SETTLE_W-1:0] settle_cnt;
    logic                is_train;

    assign is_train = (rx_word == TRAIN_WORD);

    always_ff @(posedge CLKDIV) begin
        if (link_rst) begin
            match_cnt  <= '0;
            settle_cnt <= '0;
            slip       <= 1'b0;
            locked     <= 1'b0;
        end else begin
            // slip is a single cycle pulse
            slip <= 1'b0;
            if (rx_stb && !locked) begin
                if (settle_cnt != '0) begin
                    // boundary still moving after the last slip
                    settle_cnt <= settle_cnt - 1'b1;
                end else if (is_train) begin
                    if (match_cnt == MATCH_W'(LOCK_MATCHES - 1)) begin
                        locked <= 1'b1;
                    end else begin
                        match_cnt <= match_cnt + 1'b1;
                    end
                end else begin
                    slip       <= 1'b1;
                    match_cnt  <= '0;
                    settle_cnt <= SETTLE_W'(SLIP_SETTLE_WORDS);
                end
            end
        end
    end

    // lock is sticky, so the boundary never moves once data flows
    a_no_slip_locked: assert property (
        @(posedge CLKDIV) disable iff (link_rst)
        locked |-> !slip
    );

endmodule

`default_nettype wire

// ==== tb_clock_gen.sv ====
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD = 100
) (
    output logic CLKDIV
);

    // free running, first rising edge half a period in
    initial begin
        CLKDIV = 1'b0;
        forever begin
            #(PERIOD / 2) CLKDIV = ~CLKDIV;
        end
    end

endmodule

`default_nettype wire

// ==== tb_serdes_link.sv ====
`default_nettype none

module tb_serdes_link;

    import serdes_pkg::*;

    localparam int DATA_WIDTH   = WORD_BITS;
    localparam int DELAY_TAPS   = 16;
    localparam int N_OFFSETS    = 4;
    localparam int RUN_WORDS    = 200;
    localparam int LOCK_TIMEOUT = 3000;
    localparam int RDY_TIMEOUT  = 200;

    localparam logic [DATA_WIDTH-1:0] TRAIN_WORD = DATA_WIDTH'(TRAIN_PATTERN);

    logic                  CLKDIV;
    logic                  RST;
    logic [DATA_WIDTH-1:0] tx_data = '0;
    logic                  tx_stb;
    logic                  o_dat;
    logic                  i_dat = 1'b0;
    logic [DATA_WIDTH-1:0] rx_data;
    logic                  rx_valid;
    logic                  locked;
    logic                  rdy;

    integer                seed;
    int                    loop_offset = 0;
    logic                  loop_hist [8] = '{default: 1'b0};
    logic [15:0]           lfsr = 16'hACE1;
    logic [DATA_WIDTH-1:0] exp_q [$];
    logic [DATA_WIDTH-1:0] tx_word = '0;
    int                    tx_bit = DATA_WIDTH;
    logic                  seen_data = 1'b0;
    int                    rx_count = 0;
    int                    cyc = 0;
    int                    last_stb_cyc = 0;
    logic                  stb_seen = 1'b0;

    tb_clock_gen #(.PERIOD(100)) u_clock (
        .CLKDIV (CLKDIV)
    );

    serdes_link #(
        .DATA_WIDTH (DATA_WIDTH),
        .DELAY_TAPS (DELAY_TAPS)
    ) DUT (
        .CLKDIV   (CLKDIV),
        .RST      (RST),
        .tx_data  (tx_data),
        .tx_stb   (tx_stb),
        .o_dat    (o_dat),
        .i_dat    (i_dat),
        .rx_data  (rx_data),
        .rx_valid (rx_valid),
        .locked   (locked),
        .rdy      (rdy)
    );

    // 16 bit galois lfsr, taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        return {1'b0, state[15:1]} ^ (state[0] ? 16'hB400 : 16'h0000);
    endfunction

    // next state whose low word is usable as data
    function automatic logic [15:0] next_word(input logic [15:0] state);
        logic [15:0] s;
        s = lfsr_step(state);
        // a data word equal to the training word would look like training
        while (s[DATA_WIDTH-1:0] == TRAIN_WORD) begin
            s = lfsr_step(s);
        end
        return s;
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("FAILED %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            $display("Simulation FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Simulation FAILED");
        $fatal(1, "run aborted");
    endtask

    // serial loopback with extra delay of loop_offset cycles
    always @(negedge CLKDIV) begin
        for (int i = 7; i > 0; i--) begin
            loop_hist[i] = loop_hist[i-1];
        end
        loop_hist[0] = o_dat;
        i_dat = loop_hist[loop_offset];
    end

    // new word on each load slot, sampled at the next rising edge
    always @(negedge CLKDIV) begin
        // loaded word leaves lsb first, one bit per cycle
        if (locked !== 1'b1) begin
            tx_bit = DATA_WIDTH;
        end else if (tx_bit < DATA_WIDTH) begin
            check_value("o_dat", 32'(o_dat), 32'(tx_word[tx_bit]));
            tx_bit = tx_bit + 1;
        end
        if (tx_stb === 1'b1) begin
            lfsr    = next_word(lfsr);
            tx_data = lfsr[DATA_WIDTH-1:0];
            exp_q.push_back(tx_data);
            tx_word = tx_data;
            tx_bit  = 0;
        end
    end

    // strobe spacing while locked
    always @(negedge CLKDIV) begin
        cyc = cyc + 1;
        if (locked !== 1'b1) begin
            stb_seen = 1'b0;
        end else if (tx_stb === 1'b1) begin
            if (stb_seen) begin
                check_value("tx_stb spacing", 32'(cyc - last_stb_cyc), 32'(DATA_WIDTH));
            end
            stb_seen     = 1'b1;
            last_stb_cyc = cyc;
        end
    end

    // received words against the sent ones, in order
    always @(negedge CLKDIV) begin
        if (rx_valid === 1'b1) begin
            // leading training words are still in flight when lock is declared
            if (seen_data || rx_data != TRAIN_WORD) begin
                if (exp_q.size() == 0) begin
                    abort_run("received a data word although no word was sent");
                end
                seen_data = 1'b1;
                check_value("rx_data", 32'(rx_data), 32'(exp_q.pop_front()));
                rx_count = rx_count + 1;
            end
        end
    end

    task automatic reset_link();
        int cycles;
        @(negedge CLKDIV);
        RST = 1'b1;
        repeat (2) @(negedge CLKDIV);
        // words in flight are lost with the reset
        exp_q.delete();
        seen_data = 1'b0;
        rx_count  = 0;
        check_value("locked", 32'(locked), 32'd0);
        check_value("tx_stb", 32'(tx_stb), 32'd0);
        check_value("rx_valid", 32'(rx_valid), 32'd0);
        check_value("rdy", 32'(rdy), 32'd0);
        RST    = 1'b0;
        cycles = 0;
        while (rdy !== 1'b1) begin
            @(negedge CLKDIV);
            cycles++;
            if (cycles <= RST_STRETCH) begin
                check_value("locked", 32'(locked), 32'd0);
                check_value("tx_stb", 32'(tx_stb), 32'd0);
                check_value("rx_valid", 32'(rx_valid), 32'd0);
            end
            if (cycles > RDY_TIMEOUT) begin
                abort_run("timeout waiting for rdy after reset");
            end
        end
        if (cycles <= RST_STRETCH + CAL_CYCLES) begin
            abort_run("rdy rose before the calibration countdown ended");
        end
    endtask

    task automatic wait_lock();
        int cycles;
        cycles = 0;
        while (locked !== 1'b1) begin
            @(negedge CLKDIV);
            cycles++;
            if (cycles > LOCK_TIMEOUT) begin
                abort_run("timeout waiting for locked");
            end
        end
    endtask

    task automatic stream_words(input int n);
        int limit;
        int cycles;
        limit  = (n + 16) * DATA_WIDTH + 200;
        cycles = 0;
        while (rx_count < n) begin
            @(negedge CLKDIV);
            cycles++;
            if (cycles > limit) begin
                abort_run("timeout waiting for received data words");
            end
        end
    endtask

    initial begin
        seed = 5;
        RST  = 1'b1;
        for (int run = 0; run < N_OFFSETS; run++) begin
            loop_offset = $unsigned($random(seed)) % 8;
            $display("loopback offset %0d", loop_offset);
            reset_link();
            wait_lock();
            stream_words(RUN_WORDS);
        end
        // reset while words are streaming, then train again
        reset_link();
        wait_lock();
        stream_words(RUN_WORDS);
        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire
